/* sources.f */
src/soc_pkg.sv
src/boot_rom.sv
src/sram_bank.sv
src/bus_port.sv
src/mem_subsys_top.sv
bench/tb_checker.sv
bench/tb_top.sv

/* run.sh */
#!/bin/sh
# Build the memory subsystem testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns \
  --top-module tb_top \
  -f sources.f \
  --Mdir obj_dir -o sim_tb

output=$(./obj_dir/sim_tb)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -q "TESTS PASSED"; then
  exit 0
fi
exit 1

/* bench/tb_top.sv */
// Fixed LFSR seed and a 256-word SRAM. Tests read only SRAM words that they have written first.
`timescale 1ns/1ns
`default_nettype none

module tb_top import soc_pkg::*; ();

  localparam int unsigned SramWords = 256;
  localparam int          SramIdxW  = $clog2(SramWords);

  // One response check per access
  localparam int NumTransactions = 244;
  localparam int CycleLimit      = NumTransactions * 12 + 100;

  localparam int TestRomRead   = 0;
  localparam int TestSramFull  = 1;
  localparam int TestSramByte  = 2;
  localparam int TestUnmapped  = 3;
  localparam int TestRomWrite  = 4;
  localparam int TestHandshake = 5;

  logic                 clk;
  logic                 rst_n;
  logic                 req;
  logic                 we;
  logic [AddrWidth-1:0] addr;
  logic [BeWidth-1:0]   be;
  logic [DataWidth-1:0] wdata;
  logic                 ack;
  logic [DataWidth-1:0] rdata;
  logic                 err;

  int          test_id;
  logic        test_done;
  int          checks;
  int          errors;
  logic [31:0] lfsr;
  int          cycle_count;

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  mem_subsys_top #(
    .SramWords ( SramWords )
  ) i_dut (
    .clk_i     ( clk       ),
    .rst_ni    ( rst_n     ),
    .req_i     ( req       ),
    .we_i      ( we        ),
    .addr_i    ( addr      ),
    .be_i      ( be        ),
    .wdata_i   ( wdata     ),
    .ack_o     ( ack       ),
    .rdata_o   ( rdata     ),
    .err_o     ( err       )
  );

  tb_checker #(
    .SramWords   ( SramWords )
  ) i_checker (
    .clk_i       ( clk       ),
    .rst_ni      ( rst_n     ),
    .req_i       ( req       ),
    .we_i        ( we        ),
    .addr_i      ( addr      ),
    .be_i        ( be        ),
    .wdata_i     ( wdata     ),
    .ack_i       ( ack       ),
    .rdata_i     ( rdata     ),
    .err_i       ( err       ),
    .test_id_i   ( test_id   ),
    .test_done_i ( test_done ),
    .checks_o    ( checks    ),
    .errors_o    ( errors    )
  );

  // ---------------------------------------------------------------------------
  // Random source
  // ---------------------------------------------------------------------------
  // Galois form of x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    logic        bit_out;
    val = '0;
    for (int i = 0; i < n; i++) begin
      bit_out = lfsr[0];
      lfsr = lfsr >> 1;
      if (bit_out) begin
        lfsr = lfsr ^ 32'h8020_0003;
      end
      val = {val[30:0], bit_out};
    end
    return val;
  endfunction

  function automatic logic mapped(input logic [AddrWidth-1:0] a);
    return ((a >= RomBase) && (a < RomBase + RomWords * 4)) ||
           ((a >= RamBase) && (a < RamBase + SramWords * 4));
  endfunction

  // ---------------------------------------------------------------------------
  // Four-phase host tasks
  // ---------------------------------------------------------------------------
  // Called on a falling edge, returns on the falling edge that sees ack low
  task automatic access(input logic wr, input logic [AddrWidth-1:0] a,
                        input logic [BeWidth-1:0] mask, input logic [DataWidth-1:0] data,
                        input int hold);
    we    = wr;
    addr  = a;
    be    = mask;
    wdata = data;
    req   = 1'b1;
    @(negedge clk);
    while (!ack) @(negedge clk);
    repeat (hold) @(negedge clk);
    req = 1'b0;
    @(negedge clk);
    while (ack) @(negedge clk);
  endtask

  task automatic read_word(input logic [AddrWidth-1:0] a);
    access(1'b0, a, 4'h0, 32'h0, int'(take_bits(2)));
  endtask

  task automatic write_word(input logic [AddrWidth-1:0] a, input logic [BeWidth-1:0] mask,
                            input logic [DataWidth-1:0] data);
    access(1'b1, a, mask, data, int'(take_bits(2)));
  endtask

  task automatic end_test();
    test_done = 1'b1;
    @(negedge clk);
    test_done = 1'b0;
  endtask

  // ---------------------------------------------------------------------------
  // Tests
  // ---------------------------------------------------------------------------
  task automatic run_rom_read();
    test_id = TestRomRead;
    for (int i = 0; i < RomWords; i++) begin
      read_word(RomBase + i * 4);
    end
    end_test();
  endtask

  task automatic run_sram_full();
    int unsigned words [32];
    test_id = TestSramFull;
    for (int i = 0; i < 32; i++) begin
      words[i] = take_bits(SramIdxW);
      write_word(RamBase + words[i] * 4, 4'hF, take_bits(32));
    end
    for (int i = 0; i < 32; i++) begin
      read_word(RamBase + words[i] * 4);
    end
    end_test();
  endtask

  // Full write first so that every byte of the word is known
  task automatic run_sram_byte();
    logic [AddrWidth-1:0] a;
    test_id = TestSramByte;
    for (int i = 0; i < 16; i++) begin
      a = RamBase + take_bits(SramIdxW) * 4;
      write_word(a, 4'hF, take_bits(32));
      for (int j = 0; j < 3; j++) begin
        write_word(a, 4'(take_bits(4)), take_bits(32));
      end
      read_word(a);
    end
    end_test();
  endtask

  task automatic run_unmapped();
    logic [AddrWidth-1:0] a;
    test_id = TestUnmapped;
    // Just outside each window edge
    read_word(RomBase - 4);
    write_word(RomBase + RomWords * 4, 4'hF, take_bits(32));
    read_word(RamBase - 4);
    read_word(RamBase + SramWords * 4);
    for (int i = 0; i < 12; i++) begin
      a = take_bits(32);
      while (mapped(a)) begin
        a = take_bits(32);
      end
      if (take_bits(1) == 32'd1) begin
        write_word(a, 4'(take_bits(4)), take_bits(32));
      end else begin
        read_word(a);
      end
    end
    end_test();
  endtask

  task automatic run_rom_write();
    logic [AddrWidth-1:0] a;
    test_id = TestRomWrite;
    for (int i = 0; i < 8; i++) begin
      a = RomBase + take_bits(RomIdxW) * 4;
      write_word(a, 4'hF, take_bits(32));
      read_word(a);
    end
    end_test();
  endtask

  // Long holds and back-to-back requests
  task automatic run_handshake();
    test_id = TestHandshake;
    access(1'b1, RamBase, 4'hF, 32'hC0DE_0001, 0);
    access(1'b0, RamBase, 4'h0, 32'h0, 8);
    access(1'b0, RomBase, 4'h0, 32'h0, 0);
    access(1'b0, RomBase + (RomWords - 1) * 4, 4'h0, 32'h0, 5);
    end_test();
  endtask

  // ---------------------------------------------------------------------------
  // Sequence and end of run
  // ---------------------------------------------------------------------------
  initial begin
    rst_n     = 1'b0;
    req       = 1'b0;
    we        = 1'b0;
    addr      = '0;
    be        = '0;
    wdata     = '0;
    test_id   = 0;
    test_done = 1'b0;
    lfsr      = 32'd89;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    run_rom_read();
    run_sram_full();
    run_sram_byte();
    run_unmapped();
    run_rom_write();
    run_handshake();
    if (checks != NumTransactions) begin
      $display("missing responses: %0d checked for %0d accesses", checks, NumTransactions);
    end
    $display("summary: %0d responses checked, %0d errors", checks, errors);
    if ((errors == 0) && (checks == NumTransactions)) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < CycleLimit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: run still busy after %0d cycles, handshake stalled", CycleLimit);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* bench/tb_checker.sv */
// Watches the host port only. SRAM words are assumed to be written before they are read.
`timescale 1ns/1ns
`default_nettype none

module tb_checker import soc_pkg::*; #(
  parameter int unsigned SramWords = 256
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 req_i,
  input  logic                 we_i,
  input  logic [AddrWidth-1:0] addr_i,
  input  logic [BeWidth-1:0]   be_i,
  input  logic [DataWidth-1:0] wdata_i,
  input  logic                 ack_i,
  input  logic [DataWidth-1:0] rdata_i,
  input  logic                 err_i,
  input  int                   test_id_i,
  input  logic                 test_done_i,
  output int                   checks_o,
  output int                   errors_o
);

  logic [DataWidth-1:0] shadow [SramWords];

  int                   req_cycles;
  logic                 req_seen;
  logic                 rst_seen;
  logic                 ack_prev;
  logic                 cap_we;
  logic [AddrWidth-1:0] cap_addr;
  logic [BeWidth-1:0]   cap_be;
  logic [DataWidth-1:0] cap_wdata;
  int                   cap_test;
  int                   checks_mark;
  int                   errors_mark;

  function automatic string test_label(input int id);
    case (id)
      0:       return "rom_read";
      1:       return "sram_full";
      2:       return "sram_byte";
      3:       return "unmapped";
      4:       return "rom_write";
      5:       return "handshake";
      default: return "unknown";
    endcase
  endfunction

  // ---------------------------------------------------------------------------
  // Reference model
  // ---------------------------------------------------------------------------
  // Error flag in the top bit, read data below it
  function automatic logic [DataWidth:0] ref_response(input logic wr,
                                                      input logic [AddrWidth-1:0] a);
    logic [DataWidth-1:0] prod;
    int unsigned          idx;
    if ((a >= RomBase) && (a < RomBase + RomWords * 4)) begin
      if (wr) begin
        return {1'b1, 32'h0};
      end
      idx  = (a - RomBase) >> 2;
      prod = idx * 32'h0101_0101;
      return {1'b0, RomSeed ^ prod};
    end
    if ((a >= RamBase) && (a < RamBase + SramWords * 4)) begin
      if (wr) begin
        return {1'b0, 32'h0};
      end
      idx = (a - RamBase) >> 2;
      return {1'b0, shadow[idx]};
    end
    return {1'b1, 32'h0};
  endfunction

  task automatic shadow_write(input logic [AddrWidth-1:0] a, input logic [BeWidth-1:0] mask,
                              input logic [DataWidth-1:0] data);
    int unsigned idx;
    if ((a >= RamBase) && (a < RamBase + SramWords * 4)) begin
      idx = (a - RamBase) >> 2;
      for (int b = 0; b < BeWidth; b++) begin
        if (mask[b]) begin
          shadow[idx][8*b +: 8] = data[8*b +: 8];
        end
      end
    end
  endtask

  task automatic compare_response();
    logic [DataWidth:0] exp_resp;
    exp_resp = ref_response(cap_we, cap_addr);
    checks_o++;
    if (err_i !== exp_resp[DataWidth]) begin
      $display("FAIL %s err_o at %h: expected %0b, actual %0b", test_label(cap_test),
               cap_addr, exp_resp[DataWidth], err_i);
      errors_o++;
    end
    if (rdata_i !== exp_resp[DataWidth-1:0]) begin
      $display("FAIL %s rdata_o at %h: expected %h, actual %h", test_label(cap_test),
               cap_addr, exp_resp[DataWidth-1:0], rdata_i);
      errors_o++;
    end
    if (cap_we) begin
      shadow_write(cap_addr, cap_be, cap_wdata);
    end
  endtask

  // ---------------------------------------------------------------------------
  // Rising edge: inputs are stable here
  // ---------------------------------------------------------------------------
  initial begin
    req_cycles  = 0;
    req_seen    = 1'b0;
    rst_seen    = 1'b0;
    cap_we      = 1'b0;
    cap_addr    = '0;
    cap_be      = '0;
    cap_wdata   = '0;
    cap_test    = 0;
    checks_mark = 0;
    errors_mark = 0;
    forever begin
      @(posedge clk_i);
      rst_seen = rst_ni;
      req_seen = req_i;
      if (!rst_ni || !req_i) begin
        req_cycles = 0;
      end else begin
        // First edge of a request is the one the DUT accepts
        if (req_cycles == 0) begin
          cap_we    = we_i;
          cap_addr  = addr_i;
          cap_be    = be_i;
          cap_wdata = wdata_i;
          cap_test  = test_id_i;
        end
        req_cycles++;
      end
      if (test_done_i) begin
        $display("%s: %0d responses checked, %0d errors", test_label(test_id_i),
                 checks_o - checks_mark, errors_o - errors_mark);
        checks_mark = checks_o;
        errors_mark = errors_o;
      end
    end
  end

  // ---------------------------------------------------------------------------
  // Falling edge: DUT outputs are stable here
  // ---------------------------------------------------------------------------
  initial begin
    checks_o = 0;
    errors_o = 0;
    ack_prev = 1'b0;
    forever begin
      @(negedge clk_i);
      if (!rst_seen) begin
        if ((ack_i !== 1'b0) || (err_i !== 1'b0) || (rdata_i !== '0)) begin
          $display("reset error: ack_o, err_o or rdata_o not zero while in reset");
          errors_o++;
        end
      end else if (ack_i && !ack_prev) begin
        if (req_cycles == 2) begin
          compare_response();
        end else begin
          $display("handshake error in %s: ack_o rose after %0d request edges, not 2",
                   test_label(cap_test), req_cycles);
          errors_o++;
        end
      end else if (ack_prev && !ack_i && req_seen) begin
        $display("handshake error: ack_o dropped while req_i was still high");
        errors_o++;
      end else if (ack_prev && ack_i && !req_seen) begin
        $display("handshake error: ack_o stayed high after req_i was sampled low");
        errors_o++;
      end else if (!ack_i && (req_cycles >= 2)) begin
        $display("handshake error: ack_o did not rise two cycles after req_i");
        errors_o++;
      end
      ack_prev = ack_i;
    end
  end

endmodule

`default_nettype wire

/* src/mem_subsys_top.sv */
// SramWords must be a power of two. The ROM window is fixed at 64 words and one host access runs at a time.
`timescale 1ns/1ns
`default_nettype none

module mem_subsys_top import soc_pkg::*; #(
  parameter int unsigned SramWords = 256
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 req_i,
  input  logic                 we_i,
  input  logic [AddrWidth-1:0] addr_i,
  input  logic [BeWidth-1:0]   be_i,
  input  logic [DataWidth-1:0] wdata_i,
  output logic                 ack_o,
  output logic [DataWidth-1:0] rdata_o,
  output logic                 err_o
);

  localparam int unsigned WordIdxW = word_idx_w(SramWords);
  localparam int unsigned SramIdxW = $clog2(SramWords);

  logic                 rom_en;
  logic                 sram_en;
  logic                 sram_we;
  logic [WordIdxW-1:0]  mem_word;
  logic [DataWidth-1:0] rom_rdata;
  logic [DataWidth-1:0] sram_rdata;

  // --------------------------------------------------------------------------
  // Host port and decoder
  // --------------------------------------------------------------------------
  bus_port #(
    .SramWords    ( SramWords  )
  ) i_bus_port (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .req_i        ( req_i      ),
    .we_i         ( we_i       ),
    .addr_i       ( addr_i     ),
    .ack_o        ( ack_o      ),
    .rdata_o      ( rdata_o    ),
    .err_o        ( err_o      ),
    .rom_en_o     ( rom_en     ),
    .sram_en_o    ( sram_en    ),
    .sram_we_o    ( sram_we    ),
    .mem_word_o   ( mem_word   ),
    .rom_rdata_i  ( rom_rdata  ),
    .sram_rdata_i ( sram_rdata )
  );

  // --------------------------------------------------------------------------
  // Slaves
  // --------------------------------------------------------------------------
  boot_rom i_boot_rom (
    .clk_i   ( clk_i                 ),
    .en_i    ( rom_en                ),
    .word_i  ( mem_word[RomIdxW-1:0] ),
    .rdata_o ( rom_rdata             )
  );

  // Byte enables and write data bypass the port
  sram_bank #(
    .SramWords ( SramWords              )
  ) i_sram_bank (
    .clk_i     ( clk_i                  ),
    .en_i      ( sram_en                ),
    .we_i      ( sram_we                ),
    .word_i    ( mem_word[SramIdxW-1:0] ),
    .be_i      ( be_i                   ),
    .wdata_i   ( wdata_i                ),
    .rdata_o   ( sram_rdata             )
  );

endmodule

`default_nettype wire

/* src/bus_port.sv */
// One four-phase access in flight at a time. Address bits [1:0] ignored, writes return zero data
`timescale 1ns/1ns
`default_nettype none

module bus_port import soc_pkg::*; #(
  parameter int unsigned SramWords = 256
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             req_i,
  input  logic                             we_i,
  input  logic [AddrWidth-1:0]             addr_i,
  output logic                             ack_o,
  output logic [DataWidth-1:0]             rdata_o,
  output logic                             err_o,
  output logic                             rom_en_o,
  output logic                             sram_en_o,
  output logic                             sram_we_o,
  output logic [word_idx_w(SramWords)-1:0] mem_word_o,
  input  logic [DataWidth-1:0]             rom_rdata_i,
  input  logic [DataWidth-1:0]             sram_rdata_i
);

  localparam int unsigned          WordIdxW  = word_idx_w(SramWords);
  localparam logic [AddrWidth-1:0] RomBytes  = AddrWidth'(RomWords * 4);
  localparam logic [AddrWidth-1:0] SramBytes = AddrWidth'(SramWords * 4);

  bus_state_e state_q, state_d;

  target_e tgt;
  target_e tgt_q;
  logic    we_q;

  logic [AddrWidth-1:0] rom_off;
  logic [AddrWidth-1:0] sram_off;

  logic                 accept;
  logic                 resp_err;
  logic [DataWidth-1:0] merged;

  // --------------------------------------------------------------------------
  // Address decode
  // --------------------------------------------------------------------------
  // Addresses below a base wrap to a large offset and fall out of range
  always_comb begin
    rom_off  = addr_i - RomBase;
    sram_off = addr_i - RamBase;
    if (rom_off < RomBytes) begin
      tgt = TGT_ROM;
    end else if (sram_off < SramBytes) begin
      tgt = TGT_SRAM;
    end else begin
      tgt = TGT_NONE;
    end
  end

  // Both windows sit on a boundary of their own size,
  // so the low address bits are the word offset in either one
  assign mem_word_o = addr_i[WordIdxW+1:2];

  // New request taken in IDLE or right after ack drops
  assign accept = req_i && ((state_q == IDLE) || (state_q == RELEASE));

  // --------------------------------------------------------------------------
  // Slave strobes
  // --------------------------------------------------------------------------
  // Memories sample these on the edge that accepts the request.
  // ROM writes never reach the ROM.
  assign rom_en_o  = accept && (tgt == TGT_ROM) && !we_i;
  assign sram_en_o = accept && (tgt == TGT_SRAM);
  assign sram_we_o = we_i;

  // --------------------------------------------------------------------------
  // Response merge
  // --------------------------------------------------------------------------
  assign resp_err = (tgt_q == TGT_NONE) || ((tgt_q == TGT_ROM) && we_q);

  always_comb begin
    if (resp_err || we_q) begin
      merged = '0;
    end else if (tgt_q == TGT_ROM) begin
      merged = rom_rdata_i;
    end else begin
      merged = sram_rdata_i;
    end
  end

  // --------------------------------------------------------------------------
  // Handshake FSM
  // --------------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE, RELEASE: begin
        // RELEASE lasts one cycle unless a new request is already up
        state_d = req_i ? ACCESS : IDLE;
      end
      ACCESS: begin
        state_d = RESP;
      end
      RESP: begin
        // Hold ack while the host keeps req_i high
        if (!req_i) begin
          state_d = RELEASE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      tgt_q   <= TGT_NONE;
      we_q    <= 1'b0;
      ack_o   <= 1'b0;
      err_o   <= 1'b0;
      rdata_o <= '0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        tgt_q <= tgt;
        we_q  <= we_i;
      end
      if (state_q == ACCESS) begin
        // Slave data is valid now, so register the response
        ack_o   <= 1'b1;
        err_o   <= resp_err;
        rdata_o <= merged;
      end else if ((state_q == RESP) && !req_i) begin
        ack_o <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* src/sram_bank.sv */
// Single-port SRAM without reset, so contents are undefined until written. Read data lags en_i by one cycle.
`timescale 1ns/1ns
`default_nettype none

module sram_bank import soc_pkg::*; #(
  parameter int unsigned SramWords = 256
) (
  input  logic                         clk_i,
  input  logic                         en_i,
  input  logic                         we_i,
  input  logic [$clog2(SramWords)-1:0] word_i,
  input  logic [BeWidth-1:0]           be_i,
  input  logic [DataWidth-1:0]         wdata_i,
  output logic [DataWidth-1:0]         rdata_o
);

  // --------------------------------------------------------------------------
  // Storage
  // --------------------------------------------------------------------------
  logic [DataWidth-1:0] mem_q [SramWords];

  logic wr_en;
  logic rd_en;

  assign wr_en = en_i & we_i;
  assign rd_en = en_i & ~we_i;

  // --------------------------------------------------------------------------
  // Write path
  // --------------------------------------------------------------------------
  // One lane per byte, each lane gated by its own enable
  for (genvar b = 0; b < BeWidth; b++) begin : g_byte_lane
    always_ff @(posedge clk_i) begin
      if (wr_en && be_i[b]) begin
        mem_q[word_i][8*b +: 8] <= wdata_i[8*b +: 8];
      end
    end
  end

  // --------------------------------------------------------------------------
  // Read path
  // --------------------------------------------------------------------------
  // A write leaves the read register untouched
  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rdata_o <= mem_q[word_i];
    end
  end

endmodule

`default_nettype wire

/* src/boot_rom.sv */
// Contents are fixed at elaboration by the seed rule and cannot be written. Read data lags en_i by one cycle.
`timescale 1ns/1ns
`default_nettype none

module boot_rom import soc_pkg::*; (
  input  logic                 clk_i,
  input  logic                 en_i,
  input  logic [RomIdxW-1:0]   word_i,
  output logic [DataWidth-1:0] rdata_o
);

  // --------------------------------------------------------------------------
  // Word store
  // --------------------------------------------------------------------------
  logic [DataWidth-1:0] rom_words [RomWords];

  // One constant per word, built from the package rule
  for (genvar i = 0; i < RomWords; i++) begin : g_rom_init
    assign rom_words[i] = rom_word(i);
  end

  // --------------------------------------------------------------------------
  // Read port
  // --------------------------------------------------------------------------
  // Boot code fetches come through here.
  // The output register holds its last word while en_i is low.
  always_ff @(posedge clk_i) begin
    if (en_i) begin
      rdata_o <= rom_words[word_i];
    end
  end

endmodule

`default_nettype wire

/* src/soc_pkg.sv */
// Fixed 32-bit map with one ROM window and one SRAM window whose size is set per instance.
`default_nettype none

package soc_pkg;

  // --------------------------------------------------------------------------
  // Bus widths
  // --------------------------------------------------------------------------
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned BeWidth   = DataWidth / 8;

  // --------------------------------------------------------------------------
  // Address map
  // --------------------------------------------------------------------------
  localparam logic [AddrWidth-1:0] RomBase  = 32'h0000_1000;
  localparam int unsigned          RomWords = 64;
  localparam int unsigned          RomIdxW  = $clog2(RomWords);
  // SRAM length comes from the SramWords module parameter
  localparam logic [AddrWidth-1:0] RamBase  = 32'h8000_0000;

  // Boot ROM contents
  localparam logic [DataWidth-1:0] RomSeed = 32'hA5C3_0F00;

  // Word i of the ROM, product wraps at 32 bits
  function automatic logic [DataWidth-1:0] rom_word(input int unsigned idx);
    logic [DataWidth-1:0] prod;
    prod = DataWidth'(idx * 32'h0101_0101);
    return RomSeed ^ prod;
  endfunction

  // Word index wide enough for the larger of the two windows
  function automatic int unsigned word_idx_w(input int unsigned sram_words);
    return (sram_words > RomWords) ? $clog2(sram_words) : $clog2(RomWords);
  endfunction

  // --------------------------------------------------------------------------
  // Enums
  // --------------------------------------------------------------------------
  typedef enum logic [1:0] {
    IDLE,
    ACCESS,
    RESP,
    RELEASE
  } bus_state_e;

  typedef enum logic [1:0] {
    TGT_ROM,
    TGT_SRAM,
    TGT_NONE
  } target_e;

endpackage

`default_nettype wire
